/* Makefile */
SIM      := verilator
TOP      := core_tb
FILELIST := verilog.f
FLAGS    := --binary -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int CYCLES_PER_RETIRE = 64;
    localparam int IMEM_WORDS        = 64;

    localparam int FN_ADD  = 0;
    localparam int FN_SLT  = 2;
    localparam int FN_SLTU = 3;
    localparam int FN_XOR  = 4;
    localparam int FN_OR   = 6;
    localparam int FN_AND  = 7;
    localparam int FN_BEQ  = 0;
    localparam int FN_BNE  = 1;
    localparam int FN_BLT  = 4;
    localparam int FN_BGE  = 5;
    localparam int F7_SUB  = 'h20;

    logic     clk;
    logic     rst_n;
    word_t    imem_addr;
    inst_t    imem_data;
    logic     retire_valid;
    logic     retire_ready;
    word_t    retire_pc;
    reg_idx_t retire_rd;
    logic     retire_we;
    word_t    retire_data;

    inst_t imem [IMEM_WORDS];
    word_t exp_pc [$];
    word_t exp_rd [$];
    word_t exp_we [$];
    word_t exp_data [$];
    word_t next_pc;
    int    cycle_count;
    int    cycle_limit;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

    core_top dut_i (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid),
        .retire_ready_i (retire_ready),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_we_o    (retire_we),
        .retire_data_o  (retire_data)
    );

    assign imem_data = imem[imem_addr[7:2]];  // same-cycle read

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the core stopped retiring", cycle_count);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // **************************************************
    // instruction encoders
    // **************************************************
    function automatic inst_t reg_op(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic inst_t imm_op(input int f3, input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic inst_t load_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic inst_t store_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic inst_t branch_to(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic inst_t upper_imm(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic inst_t jump_link(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // **************************************************
    // program loading and retire collection
    // **************************************************
    task automatic clear_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i[5:0]] = {i[24:0], 7'b0001011};  // custom opcode, no-op
        end
        next_pc = '0;
    endtask

    task automatic expect_inst(input inst_t inst, input logic we, input word_t data);
        imem[next_pc[7:2]] = inst;
        exp_pc.push_back(next_pc);
        exp_rd.push_back(word_t'(inst[11:7]));  // raw rd field, also for sw and branches
        exp_we.push_back(word_t'(we));
        exp_data.push_back(data);
        cycle_limit = cycle_limit + CYCLES_PER_RETIRE;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic skip_inst(input inst_t inst);
        imem[next_pc[7:2]] = inst;  // branched over, never retires
        next_pc = next_pc + 32'd4;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        retire_ready = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #2;
            compare(word_t'(retire_valid), 32'd0, "retire valid in reset");
            compare(imem_addr, 32'd0, "fetch address in reset");
        end
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        compare(word_t'(retire_valid), 32'd0, "retire valid after reset");
        compare(imem_addr, 32'd4, "fetch address after first fetch");
    endtask

    task automatic run_program(input logic random_ready);
        word_t pc;
        word_t rd;
        word_t we;
        word_t data;
        apply_reset();
        while (exp_pc.size() > 0) begin
            @(posedge clk);
            #2;
            if (random_ready) begin
                retire_ready = ($urandom & 32'h3) != 32'h0;
            end else begin
                retire_ready = 1'b1;
            end
            if (retire_valid && retire_ready) begin  // transfers on the next edge
                pc   = exp_pc.pop_front();
                rd   = exp_rd.pop_front();
                we   = exp_we.pop_front();
                data = exp_data.pop_front();
                compare(retire_pc, pc, "retire pc");
                compare(word_t'(retire_rd), rd, $sformatf("rd at pc %h", pc));
                compare(word_t'(retire_we), we, $sformatf("write enable at pc %h", pc));
                compare(retire_data, data, $sformatf("data at pc %h", pc));
            end
        end
        retire_ready = 1'b1;
    endtask

    // **************************************************
    // directed tests
    // **************************************************
    task automatic reset_behavior();
        clear_program();
        apply_reset();
    endtask

    task automatic arithmetic_ops();
        clear_program();
        expect_inst(imm_op(FN_ADD, 1, 0, 5), 1'b1, 32'd5);
        expect_inst(imm_op(FN_ADD, 2, 0, -3), 1'b1, 32'hffff_fffd);
        expect_inst(upper_imm(5, 'h12345), 1'b1, 32'h1234_5000);
        expect_inst(imm_op(FN_OR, 6, 0, 'hf0), 1'b1, 32'h0000_00f0);
        expect_inst(reg_op(0, FN_ADD, 3, 1, 2), 1'b1, 32'd2);
        expect_inst(reg_op(F7_SUB, FN_ADD, 4, 1, 2), 1'b1, 32'd8);
        expect_inst(reg_op(0, FN_AND, 7, 1, 6), 1'b1, 32'd0);
        expect_inst(reg_op(0, FN_OR, 8, 1, 6), 1'b1, 32'h0000_00f5);
        expect_inst(reg_op(0, FN_XOR, 9, 2, 6), 1'b1, 32'hffff_ff0d);
        expect_inst(reg_op(0, FN_SLT, 10, 2, 1), 1'b1, 32'd1);
        expect_inst(reg_op(0, FN_SLTU, 11, 2, 1), 1'b1, 32'd0);
        expect_inst(reg_op(0, FN_SLT, 15, 1, 2), 1'b1, 32'd0);
        expect_inst(reg_op(0, FN_SLTU, 16, 1, 2), 1'b1, 32'd1);
        expect_inst(imm_op(FN_XOR, 12, 1, -1), 1'b1, 32'hffff_fffa);
        expect_inst(imm_op(FN_AND, 13, 2, 'h7f), 1'b1, 32'h0000_007d);
        expect_inst(imm_op(FN_SLT, 14, 1, 6), 1'b1, 32'd1);
        expect_inst(imm_op(FN_ADD, 0, 1, 7), 1'b1, 32'd0);   // x0 stays zero
        expect_inst(reg_op(0, FN_ADD, 0, 1, 1), 1'b1, 32'd0);
        expect_inst(jump_link(0, 0), 1'b1, 32'd0);
        run_program(1'b0);
    endtask

    task automatic dependent_chains();
        clear_program();
        expect_inst(imm_op(FN_ADD, 1, 0, 1), 1'b1, 32'd1);
        expect_inst(imm_op(FN_ADD, 1, 1, 2), 1'b1, 32'd3);    // distance 1
        expect_inst(imm_op(FN_ADD, 2, 0, 10), 1'b1, 32'd10);
        expect_inst(reg_op(0, FN_ADD, 3, 1, 2), 1'b1, 32'd13); // distances 2 and 1
        expect_inst(imm_op(FN_ADD, 4, 0, 7), 1'b1, 32'd7);
        expect_inst(imm_op(FN_ADD, 0, 0, 0), 1'b1, 32'd0);
        expect_inst(imm_op(FN_ADD, 6, 3, 1), 1'b1, 32'd14);    // distance 3
        expect_inst(reg_op(F7_SUB, FN_ADD, 7, 6, 4), 1'b1, 32'd7);
        expect_inst(reg_op(0, FN_ADD, 8, 7, 7), 1'b1, 32'd14);
        expect_inst(reg_op(0, FN_XOR, 9, 8, 1), 1'b1, 32'd13);
        expect_inst(upper_imm(10, 'habcde), 1'b1, 32'habcd_e000);
        expect_inst(imm_op(FN_ADD, 10, 10, 'h123), 1'b1, 32'habcd_e123);
        expect_inst(jump_link(0, 0), 1'b1, 32'd0);
        run_program(1'b0);
    endtask

    task automatic build_memory_program();
        clear_program();
        expect_inst(imm_op(FN_ADD, 1, 0, 'h40), 1'b1, 32'h0000_0040);
        expect_inst(upper_imm(2, 'hdeadb), 1'b1, 32'hdead_b000);
        expect_inst(imm_op(FN_ADD, 2, 2, 'h6ef), 1'b1, 32'hdead_b6ef);
        expect_inst(store_word(2, 1, 8), 1'b0, 32'd0);
        expect_inst(load_word(3, 1, 8), 1'b1, 32'hdead_b6ef);
        expect_inst(imm_op(FN_ADD, 4, 0, 'h123), 1'b1, 32'h0000_0123);
        expect_inst(store_word(4, 1, 12), 1'b0, 32'd0);
        expect_inst(load_word(5, 1, 12), 1'b1, 32'h0000_0123);
        expect_inst(reg_op(0, FN_ADD, 6, 5, 3), 1'b1, 32'hdead_b812);  // load-use
        expect_inst(store_word(6, 1, -4), 1'b0, 32'd0);
        expect_inst(load_word(7, 1, -4), 1'b1, 32'hdead_b812);
        expect_inst(imm_op(FN_ADD, 8, 7, 1), 1'b1, 32'hdead_b813);
        expect_inst(jump_link(0, 0), 1'b1, 32'd0);
    endtask

    task automatic memory_ops();
        build_memory_program();
        run_program(1'b0);
    endtask

    task automatic control_flow();
        clear_program();
        expect_inst(imm_op(FN_ADD, 1, 0, 5), 1'b1, 32'd5);
        expect_inst(imm_op(FN_ADD, 2, 0, -2), 1'b1, 32'hffff_fffe);
        expect_inst(branch_to(FN_BEQ, 1, 1, 8), 1'b0, 32'd0);   // taken
        skip_inst(imm_op(FN_ADD, 3, 0, 99));
        expect_inst(branch_to(FN_BEQ, 1, 2, 8), 1'b0, 32'd0);
        expect_inst(imm_op(FN_ADD, 3, 0, 1), 1'b1, 32'd1);
        expect_inst(branch_to(FN_BNE, 1, 2, 8), 1'b0, 32'd0);   // taken
        skip_inst(imm_op(FN_ADD, 3, 0, 99));
        expect_inst(branch_to(FN_BNE, 1, 1, 8), 1'b0, 32'd0);
        expect_inst(imm_op(FN_ADD, 4, 0, 2), 1'b1, 32'd2);
        expect_inst(branch_to(FN_BLT, 2, 1, 8), 1'b0, 32'd0);   // -2 < 5
        skip_inst(imm_op(FN_ADD, 4, 0, 99));
        expect_inst(branch_to(FN_BLT, 1, 2, 8), 1'b0, 32'd0);
        expect_inst(imm_op(FN_ADD, 5, 0, 3), 1'b1, 32'd3);
        expect_inst(branch_to(FN_BGE, 1, 2, 8), 1'b0, 32'd0);   // taken
        skip_inst(imm_op(FN_ADD, 5, 0, 99));
        expect_inst(branch_to(FN_BGE, 2, 1, 8), 1'b0, 32'd0);
        expect_inst(jump_link(6, 8), 1'b1, 32'd72);              // link is pc+4
        skip_inst(imm_op(FN_ADD, 6, 0, 99));
        expect_inst(reg_op(0, FN_ADD, 7, 6, 5), 1'b1, 32'd75);
        expect_inst(jump_link(0, 0), 1'b1, 32'd0);
        run_program(1'b0);
    endtask

    task automatic backpressure();
        build_memory_program();
        run_program(1'b1);
    endtask

    initial begin
        void'($urandom(32'hbfa01ca1));
        rst_n        = 1'b0;
        retire_ready = 1'b1;
        cycle_count  = 0;
        cycle_limit  = CYCLES_PER_RETIRE;  // covers the standalone reset test
        reset_behavior();
        arithmetic_ops();
        dependent_chains();
        memory_ops();
        control_flow();
        backpressure();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;  // free running

endmodule

/* hw/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// **************************************************
// architectural sizes
// **************************************************
`define XLEN       32
`define NUM_REGS   32
`define DMEM_WORDS 256           // words, 1 KiB

// **************************************************
// opcodes and function codes
// **************************************************
`define OP_REG     7'b0110011
`define OP_IMM     7'b0010011
`define OP_LUI     7'b0110111
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_BRANCH  7'b1100011
`define OP_JAL     7'b1101111

`define F3_ADD     3'b000        // add, sub, addi
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_WORD    3'b010        // lw and sw
`define F3_BEQ     3'b000
`define F3_BNE     3'b001
`define F3_BLT     3'b100
`define F3_BGE     3'b101

`define F7_SUB     7'b0100000

// alu op codes
`define ALU_ADD    3'd0
`define ALU_SUB    3'd1
`define ALU_AND    3'd2
`define ALU_OR     3'd3
`define ALU_XOR    3'd4
`define ALU_SLT    3'd5
`define ALU_SLTU   3'd6
`define ALU_PASS_B 3'd7

`endif

/* hw/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]               word_t;     // data or address
    typedef logic [31:0]                    inst_t;
    typedef logic [$clog2(`NUM_REGS)-1:0]   reg_idx_t;
    typedef logic [2:0]                     alu_op_t;   // see ALU_* codes

endpackage

/* hw/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    output word_t    imem_addr_o,
    input  inst_t    imem_data_i,
    output logic     retire_valid_o,
    input  logic     retire_ready_i,
    output word_t    retire_pc_o,
    output reg_idx_t retire_rd_o,
    output logic     retire_we_o,
    output word_t    retire_data_o
);

    logic     if_valid;
    word_t    if_pc;
    inst_t    if_inst;
    logic     id_ready;
    logic     redirect;
    word_t    redirect_pc;

    logic     id_valid;
    word_t    id_pc;
    alu_op_t  id_alu_op;
    word_t    id_op_a;
    word_t    id_op_b;
    word_t    id_store_data;
    reg_idx_t id_rd;
    logic     id_rd_we;
    logic     id_is_load;
    logic     id_is_store;
    logic     ex_ready;

    logic     ex_valid;
    word_t    ex_pc;
    word_t    ex_result;
    word_t    ex_store_data;
    reg_idx_t ex_rd;
    logic     ex_rd_we;
    logic     ex_is_load;
    logic     ex_is_store;
    logic     mem_ready;

    logic     mem_fwd_valid;
    reg_idx_t mem_fwd_rd;
    word_t    mem_fwd_data;

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .id_ready_i    (id_ready),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .if_valid_o    (if_valid),
        .if_pc_o       (if_pc),
        .if_inst_o     (if_inst)
    );

    // the hazard check looks at the item now held for execute
    decode_stage u_decode (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .if_valid_i      (if_valid),
        .if_pc_i         (if_pc),
        .if_inst_i       (if_inst),
        .id_ready_o      (id_ready),
        .redirect_o      (redirect),
        .redirect_pc_o   (redirect_pc),
        .ex_ready_i      (ex_ready),
        .ex_valid_i      (id_valid),
        .ex_rd_i         (id_rd),
        .ex_rd_we_i      (id_rd_we),
        .mem_fwd_valid_i (mem_fwd_valid),
        .mem_fwd_rd_i    (mem_fwd_rd),
        .mem_fwd_data_i  (mem_fwd_data),
        .wb_valid_i      (retire_valid_o),
        .wb_ready_i      (retire_ready_i),
        .wb_rd_i         (retire_rd_o),
        .wb_we_i         (retire_we_o),
        .wb_data_i       (retire_data_o),
        .id_valid_o      (id_valid),
        .id_pc_o         (id_pc),
        .id_alu_op_o     (id_alu_op),
        .id_op_a_o       (id_op_a),
        .id_op_b_o       (id_op_b),
        .id_store_data_o (id_store_data),
        .id_rd_o         (id_rd),
        .id_rd_we_o      (id_rd_we),
        .id_is_load_o    (id_is_load),
        .id_is_store_o   (id_is_store)
    );

    exec_stage u_exec (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .id_valid_i      (id_valid),
        .id_pc_i         (id_pc),
        .id_alu_op_i     (id_alu_op),
        .id_op_a_i       (id_op_a),
        .id_op_b_i       (id_op_b),
        .id_store_data_i (id_store_data),
        .id_rd_i         (id_rd),
        .id_rd_we_i      (id_rd_we),
        .id_is_load_i    (id_is_load),
        .id_is_store_i   (id_is_store),
        .ex_ready_o      (ex_ready),
        .mem_ready_i     (mem_ready),
        .ex_valid_o      (ex_valid),
        .ex_pc_o         (ex_pc),
        .ex_result_o     (ex_result),
        .ex_store_data_o (ex_store_data),
        .ex_rd_o         (ex_rd),
        .ex_rd_we_o      (ex_rd_we),
        .ex_is_load_o    (ex_is_load),
        .ex_is_store_o   (ex_is_store)
    );

    mem_stage u_mem (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_valid_i      (ex_valid),
        .ex_pc_i         (ex_pc),
        .ex_result_i     (ex_result),
        .ex_store_data_i (ex_store_data),
        .ex_rd_i         (ex_rd),
        .ex_rd_we_i      (ex_rd_we),
        .ex_is_load_i    (ex_is_load),
        .ex_is_store_i   (ex_is_store),
        .mem_ready_o     (mem_ready),
        .mem_fwd_valid_o (mem_fwd_valid),
        .mem_fwd_rd_o    (mem_fwd_rd),
        .mem_fwd_data_o  (mem_fwd_data),
        .retire_ready_i  (retire_ready_i),
        .retire_valid_o  (retire_valid_o),
        .retire_pc_o     (retire_pc_o),
        .retire_rd_o     (retire_rd_o),
        .retire_we_o     (retire_we_o),
        .retire_data_o   (retire_data_o)
    );

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     if_valid_i,
    input  word_t    if_pc_i,
    input  inst_t    if_inst_i,
    output logic     id_ready_o,
    output logic     redirect_o,
    output word_t    redirect_pc_o,
    input  logic     ex_ready_i,
    input  logic     ex_valid_i,
    input  reg_idx_t ex_rd_i,
    input  logic     ex_rd_we_i,
    input  logic     mem_fwd_valid_i,
    input  reg_idx_t mem_fwd_rd_i,
    input  word_t    mem_fwd_data_i,
    input  logic     wb_valid_i,
    input  logic     wb_ready_i,
    input  reg_idx_t wb_rd_i,
    input  logic     wb_we_i,
    input  word_t    wb_data_i,
    output logic     id_valid_o,
    output word_t    id_pc_o,
    output alu_op_t  id_alu_op_o,
    output word_t    id_op_a_o,
    output word_t    id_op_b_o,
    output word_t    id_store_data_o,
    output reg_idx_t id_rd_o,
    output logic     id_rd_we_o,
    output logic     id_is_load_o,
    output logic     id_is_store_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      rf_rs1;
    word_t      rf_rs2;
    word_t      rs1_val;
    word_t      rs2_val;
    alu_op_t    alu_op;
    word_t      op_b;
    logic       rd_we;
    logic       is_load;
    logic       is_store;
    logic       use_rs1;
    logic       use_rs2;
    logic       br_taken;
    word_t      br_target;
    logic       stall;
    logic       id_reg_free;

    assign opcode = if_inst_i[6:0];
    assign rd     = if_inst_i[11:7];
    assign funct3 = if_inst_i[14:12];
    assign rs1    = if_inst_i[19:15];
    assign rs2    = if_inst_i[24:20];
    assign funct7 = if_inst_i[31:25];

    assign imm_i = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
    assign imm_s = {{20{if_inst_i[31]}}, if_inst_i[31:25], if_inst_i[11:7]};
    assign imm_b = {{19{if_inst_i[31]}}, if_inst_i[31], if_inst_i[7],
                    if_inst_i[30:25], if_inst_i[11:8], 1'b0};
    assign imm_u = {if_inst_i[31:12], 12'b0};
    assign imm_j = {{11{if_inst_i[31]}}, if_inst_i[31], if_inst_i[19:12],
                    if_inst_i[20], if_inst_i[30:21], 1'b0};

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .we_i       (wb_valid_i && wb_ready_i && wb_we_i),  // on retire only
        .rd_i       (wb_rd_i),
        .wd_i       (wb_data_i),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    // **************************************************
    // operand bypass
    // **************************************************
    function automatic word_t bypass(input reg_idx_t idx, input word_t rf_val);
        word_t val;
        val = rf_val;
        if (idx != '0 && wb_valid_i && wb_we_i && wb_rd_i == idx) begin
            val = wb_data_i;
        end
        if (idx != '0 && mem_fwd_valid_i && mem_fwd_rd_i == idx) begin
            val = mem_fwd_data_i;                     // younger producer wins
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = bypass(rs1, rf_rs1);
        rs2_val = bypass(rs2, rf_rs2);
    end

    // **************************************************
    // decoder and branch resolution
    // **************************************************
    always_comb begin
        alu_op    = `ALU_ADD;
        op_b      = imm_i;
        rd_we     = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        br_taken  = 1'b0;
        br_target = if_pc_i + imm_b;
        case (opcode)
            `OP_REG: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                op_b    = rs2_val;
                rd_we   = 1'b1;
                case (funct3)
                    `F3_ADD:  alu_op = (funct7 == `F7_SUB) ? `ALU_SUB : `ALU_ADD;
                    `F3_SLT:  alu_op = `ALU_SLT;
                    `F3_SLTU: alu_op = `ALU_SLTU;
                    `F3_XOR:  alu_op = `ALU_XOR;
                    `F3_OR:   alu_op = `ALU_OR;
                    `F3_AND:  alu_op = `ALU_AND;
                    default:  rd_we  = 1'b0;          // shifts
                endcase
                if (funct7 != '0 && (funct7 != `F7_SUB || funct3 != `F3_ADD)) begin
                    rd_we = 1'b0;                     // mul/div and friends
                end
            end
            `OP_IMM: begin
                use_rs1 = 1'b1;
                rd_we   = 1'b1;
                case (funct3)
                    `F3_ADD: alu_op = `ALU_ADD;
                    `F3_SLT: alu_op = `ALU_SLT;
                    `F3_XOR: alu_op = `ALU_XOR;
                    `F3_OR:  alu_op = `ALU_OR;
                    `F3_AND: alu_op = `ALU_AND;
                    default: rd_we  = 1'b0;           // sltiu, shifts
                endcase
            end
            `OP_LUI: begin
                alu_op = `ALU_PASS_B;
                op_b   = imm_u;
                rd_we  = 1'b1;
            end
            `OP_LOAD: begin
                use_rs1 = 1'b1;
                rd_we   = (funct3 == `F3_WORD);
                is_load = (funct3 == `F3_WORD);
            end
            `OP_STORE: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                op_b     = imm_s;
                is_store = (funct3 == `F3_WORD);
            end
            `OP_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    `F3_BEQ: br_taken = (rs1_val == rs2_val);
                    `F3_BNE: br_taken = (rs1_val != rs2_val);
                    `F3_BLT: br_taken = ($signed(rs1_val) < $signed(rs2_val));
                    `F3_BGE: br_taken = ($signed(rs1_val) >= $signed(rs2_val));
                    default: br_taken = 1'b0;
                endcase
            end
            `OP_JAL: begin
                alu_op    = `ALU_PASS_B;
                op_b      = if_pc_i + word_t'(4);     // link value
                rd_we     = 1'b1;
                br_taken  = 1'b1;
                br_target = if_pc_i + imm_j;
            end
            default: begin
                rd_we = 1'b0;                         // retires as a no-op
            end
        endcase
    end

    // producer still in execute has no bypass source yet
    assign stall = ex_valid_i && ex_rd_we_i && ex_rd_i != '0 &&
                   ((use_rs1 && rs1 == ex_rd_i) || (use_rs2 && rs2 == ex_rd_i));

    assign id_reg_free   = !id_valid_o || ex_ready_i;
    assign id_ready_o    = id_reg_free && !stall;
    assign redirect_o    = if_valid_i && id_ready_o && br_taken;
    assign redirect_pc_o = br_target;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid_o <= 1'b0;
        end else if (id_reg_free) begin
            id_valid_o <= if_valid_i && !stall;       // bubble on stall
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid_i && id_ready_o) begin
            id_pc_o         <= if_pc_i;
            id_alu_op_o     <= alu_op;
            id_op_a_o       <= rs1_val;
            id_op_b_o       <= op_b;
            id_store_data_o <= rs2_val;
            id_rd_o         <= rd;
            id_rd_we_o      <= rd_we;
            id_is_load_o    <= is_load;
            id_is_store_o   <= is_store;
        end
    end

endmodule

/* hw/exec_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module exec_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     id_valid_i,
    input  word_t    id_pc_i,
    input  alu_op_t  id_alu_op_i,
    input  word_t    id_op_a_i,
    input  word_t    id_op_b_i,
    input  word_t    id_store_data_i,
    input  reg_idx_t id_rd_i,
    input  logic     id_rd_we_i,
    input  logic     id_is_load_i,
    input  logic     id_is_store_i,
    output logic     ex_ready_o,
    input  logic     mem_ready_i,
    output logic     ex_valid_o,
    output word_t    ex_pc_o,
    output word_t    ex_result_o,
    output word_t    ex_store_data_o,
    output reg_idx_t ex_rd_o,
    output logic     ex_rd_we_o,
    output logic     ex_is_load_o,
    output logic     ex_is_store_o
);

    word_t alu_result;

    always_comb begin
        case (id_alu_op_i)
            `ALU_ADD:  alu_result = id_op_a_i + id_op_b_i;  // also load/store address
            `ALU_SUB:  alu_result = id_op_a_i - id_op_b_i;
            `ALU_AND:  alu_result = id_op_a_i & id_op_b_i;
            `ALU_OR:   alu_result = id_op_a_i | id_op_b_i;
            `ALU_XOR:  alu_result = id_op_a_i ^ id_op_b_i;
            `ALU_SLT:  alu_result = word_t'($signed(id_op_a_i) < $signed(id_op_b_i));
            `ALU_SLTU: alu_result = word_t'(id_op_a_i < id_op_b_i);
            default:   alu_result = id_op_b_i;              // pass b for lui, jal
        endcase
    end

    assign ex_ready_o = !ex_valid_o || mem_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else if (ex_ready_o) begin
            ex_valid_o <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid_i && ex_ready_o) begin
            ex_pc_o         <= id_pc_i;
            ex_result_o     <= alu_result;
            ex_store_data_o <= id_store_data_i;
            ex_rd_o         <= id_rd_i;
            ex_rd_we_o      <= id_rd_we_i;
            ex_is_load_o    <= id_is_load_i;
            ex_is_store_o   <= id_is_store_i;
        end
    end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    output word_t imem_addr_o,
    input  inst_t imem_data_i,
    input  logic  id_ready_i,
    input  logic  redirect_i,
    input  word_t redirect_pc_i,
    output logic  if_valid_o,
    output word_t if_pc_o,
    output inst_t if_inst_o
);

    word_t pc_q;
    logic  if_ready;

    assign if_ready    = !if_valid_o || id_ready_i;  // slot empty or draining
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= '0;
            if_valid_o <= 1'b0;
        end else if (redirect_i) begin
            pc_q       <= redirect_pc_i;
            if_valid_o <= 1'b0;                       // wrong-path fetch dropped
        end else if (if_ready) begin
            pc_q       <= pc_q + word_t'(4);
            if_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (if_ready) begin
            if_pc_o   <= pc_q;
            if_inst_o <= imem_data_i;
        end
    end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module mem_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     ex_valid_i,
    input  word_t    ex_pc_i,
    input  word_t    ex_result_i,
    input  word_t    ex_store_data_i,
    input  reg_idx_t ex_rd_i,
    input  logic     ex_rd_we_i,
    input  logic     ex_is_load_i,
    input  logic     ex_is_store_i,
    output logic     mem_ready_o,
    output logic     mem_fwd_valid_o,
    output reg_idx_t mem_fwd_rd_o,
    output word_t    mem_fwd_data_o,
    input  logic     retire_ready_i,
    output logic     retire_valid_o,
    output word_t    retire_pc_o,
    output reg_idx_t retire_rd_o,
    output logic     retire_we_o,
    output word_t    retire_data_o
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    word_t              dmem [`DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_idx;
    word_t              load_data;
    word_t              wb_value;
    logic               accept;

    assign dmem_idx    = ex_result_i[DMEM_AW+1:2];        // word addressed
    assign load_data   = dmem[dmem_idx];
    assign mem_ready_o = !retire_valid_o || retire_ready_i;
    assign accept      = ex_valid_i && mem_ready_o;

    // x0 and non-writing instructions report zero
    assign wb_value = (!ex_rd_we_i || ex_rd_i == '0) ? '0 :
                      (ex_is_load_i ? load_data : ex_result_i);

    always_ff @(posedge clk) begin
        if (accept && ex_is_store_i) begin
            dmem[dmem_idx] <= ex_store_data_i;            // once, on transfer
        end
    end

    assign mem_fwd_valid_o = ex_valid_i && ex_rd_we_i;
    assign mem_fwd_rd_o    = ex_rd_i;
    assign mem_fwd_data_o  = wb_value;

    // **************************************************
    // write-back register
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
        end else if (mem_ready_o) begin
            retire_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            retire_pc_o   <= ex_pc_i;
            retire_rd_o   <= ex_rd_i;
            retire_we_o   <= ex_rd_we_i;
            retire_data_o <= wb_value;
        end
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  logic     we_i,
    input  reg_idx_t rd_i,
    input  word_t    wd_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wd_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];  // x0 hardwired
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* verilog.f */
+incdir+hw
hw/core_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/exec_stage.sv
hw/mem_stage.sv
hw/core_top.sv
dv/tb_clock.sv
dv/core_tb.sv
